/* isaPkg.sv */
package isaPkg;

	typedef logic [17:0] instrT;
	typedef logic [15:0] dataT;
	typedef logic [3:0] regSelT;
	typedef logic [3:0] opcodeT;

	typedef struct packed {
		logic low;
		logic negative;
		logic zero;
	} flagsT;

	localparam int NUM_REGS = 16;
	localparam regSelT LINK_REG = 4'd12;
	localparam regSelT SP_REG = 4'd13;

	////////////////////////////// Type and N-type fields
	localparam logic [1:0] TYPE_N = 2'b00;
	localparam opcodeT N_REG_ALU = 4'd0;
	localparam opcodeT N_MEM_REG = 4'd1;
	localparam opcodeT MOVMR = 4'd0;
	localparam opcodeT MOVRM = 4'd1;

	// ALU opcodes, 0 and 1 reused internally for INCR/DECR
	localparam opcodeT ALU_INC = 4'd0;
	localparam opcodeT ALU_DEC = 4'd1;
	localparam opcodeT ADD = 4'd2;
	localparam opcodeT SUB = 4'd3;
	localparam opcodeT AND = 4'd4;
	localparam opcodeT OR = 4'd5;
	localparam opcodeT XOR = 4'd6;
	localparam opcodeT NOT = 4'd7;
	localparam opcodeT LSH = 4'd8;
	localparam opcodeT RSH = 4'd9;
	localparam opcodeT ARSH = 4'd10;
	localparam opcodeT CMP = 4'd11;
	localparam opcodeT MOVR = 4'd12;
	localparam opcodeT MUL = 4'd13;
	localparam opcodeT FMUL = 4'd14;

	////////////////////////////// Specials in [17:14]
	localparam opcodeT CALL = 4'd4;
	localparam opcodeT MOVMRI = 4'd5;
	localparam opcodeT MOVRMI = 4'd6;
	localparam opcodeT RET = 4'd7;
	localparam opcodeT JL = 4'd8;
	localparam opcodeT JLE = 4'd9;
	localparam opcodeT JNE = 4'd10;
	localparam opcodeT JE = 4'd11;
	localparam opcodeT POP = 4'd12;
	localparam opcodeT PUSH = 4'd13;
	localparam opcodeT PUSHI = 4'd14;
	localparam opcodeT INCDEC = 4'd15;
	localparam logic [1:0] INCR = 2'd0;
	localparam logic [1:0] DECR = 2'd1;

endpackage

/* corePkg.sv */
package corePkg;

	typedef enum logic [1:0] {
		ST_FETCH,
		ST_EXEC,
		ST_MEM,
		ST_WB
	} seqStateT;

	// ALU B operand source
	typedef enum logic {
		OPB_REG,
		OPB_IMM
	} operandSelT;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PCLINK
	} wbDataSelT;

	typedef enum logic [1:0] {
		PC_INC,
		PC_JUMP,
		PC_LINK
	} pcSelT;

	// Bus address source
	typedef enum logic [1:0] {
		ADR_PC,
		ADR_IMM,
		ADR_SRCREG,
		ADR_SP
	} addrSelT;

endpackage

/* ctrlIf.sv */
interface ctrlIf;
	import isaPkg::*;
	import corePkg::*;

	opcodeT aluOp;
	regSelT destSel, destSel2, srcSel;
	dataT immediate, address;
	operandSelT operandSel;
	wbDataSelT wbDataSel;
	addrSelT addrSel;
	pcSelT pcSel;
	logic writeEn1, writeEn2, flagWrite, pcLoad;
	logic memWrite, busReq;

	modport ctrl (
		output aluOp, destSel, destSel2, srcSel, immediate, address,
		output operandSel, wbDataSel, addrSel, pcSel,
		output writeEn1, writeEn2, flagWrite, pcLoad, memWrite, busReq
	);

	modport dp (
		input aluOp, destSel, destSel2, srcSel, immediate, address,
		input operandSel, wbDataSel, addrSel, pcSel,
		input writeEn1, writeEn2, flagWrite, pcLoad, memWrite, busReq
	);

endinterface

/* controlUnit.sv */
module controlUnit (
	input  logic          clk,
	input  logic          rst,
	input  isaPkg::instrT instruction,
	input  isaPkg::flagsT flags,
	input  logic          busDone,
	ctrlIf.ctrl           ctrl
);
	import isaPkg::*;
	import corePkg::*;

	seqStateT state;
	instrT instrReg;
	opcodeT special, op;
	regSelT dst;
	addrSelT addrSelDec;
	logic wrDest, wrSp, flagWr, isMem, storeOp;
	logic takeJump, highDst, wbPhase;

	function automatic logic isHighReg(regSelT r);
		return (r == LINK_REG) || (r == SP_REG);
	endfunction

	assign special = instrReg[17:14];

	// Branch conditions on the current flags
	always_comb begin
		case (special)
			JL: takeJump = flags.low | flags.negative;
			JLE: takeJump = flags.low | flags.negative | flags.zero;
			JNE: takeJump = !flags.zero;
			JE: takeJump = flags.zero;
			default: takeJump = 1'b0;
		endcase
	end

	////////////////////////////// Decode
	always_comb begin
		op = instrReg[7:4];
		dst = instrReg[11:8];
		ctrl.srcSel = instrReg[3:0];
		ctrl.immediate = {8'd0, instrReg[7:0]};
		ctrl.address = {2'd0, instrReg[13:0]};
		ctrl.operandSel = OPB_REG;
		ctrl.wbDataSel = WB_ALU;
		ctrl.pcSel = PC_INC;
		addrSelDec = ADR_SRCREG;
		wrDest = 1'b0;
		wrSp = 1'b0;
		flagWr = 1'b0;
		isMem = 1'b0;
		storeOp = 1'b0;
		if (instrReg[17:16] == TYPE_N) begin
			if (instrReg[15:12] == N_MEM_REG) begin
				if (instrReg[7:4] == MOVMR) begin
					isMem = 1'b1;
					wrDest = 1'b1;
					ctrl.wbDataSel = WB_MEM;
				end else if (instrReg[7:4] == MOVRM) begin
					isMem = 1'b1;
					storeOp = 1'b1;
				end
			end else begin
				// Immediate form keeps its opcode in [15:12]
				if (instrReg[15:12] != N_REG_ALU) begin
					op = instrReg[15:12];
					ctrl.operandSel = OPB_IMM;
					ctrl.srcSel = dst;
				end
				if (op inside {[ADD:ARSH]}) begin
					flagWr = 1'b1;
					wrDest = 1'b1;
				end else if (op == CMP) begin
					flagWr = 1'b1;
				end else if (op == MOVR) begin
					wrDest = 1'b1;
				end
			end
		end else begin
			case (special)
				CALL: begin
					dst = LINK_REG;
					wrDest = 1'b1;
					ctrl.wbDataSel = WB_PCLINK;
					ctrl.pcSel = PC_JUMP;
				end
				MOVMRI: begin
					isMem = 1'b1;
					wrDest = 1'b1;
					ctrl.wbDataSel = WB_MEM;
					addrSelDec = ADR_IMM;
				end
				MOVRMI: begin
					isMem = 1'b1;
					storeOp = 1'b1;
					addrSelDec = ADR_IMM;
				end
				RET: begin
					ctrl.srcSel = LINK_REG;
					ctrl.pcSel = PC_LINK;
				end
				JL, JLE, JNE, JE: begin
					if (takeJump)
						ctrl.pcSel = PC_JUMP;
				end
				POP: begin
					dst = instrReg[13:10];
					addrSelDec = ADR_SP;
					// Never pop into the link register or SP
					if (!isHighReg(instrReg[13:10])) begin
						isMem = 1'b1;
						wrDest = 1'b1;
						wrSp = 1'b1;
						ctrl.wbDataSel = WB_MEM;
					end
				end
				PUSH: begin
					dst = instrReg[13:10];
					addrSelDec = ADR_SP;
					isMem = 1'b1;
					storeOp = 1'b1;
					wrSp = 1'b1;
				end
				INCDEC: begin
					if (instrReg[13:12] == INCR || instrReg[13:12] == DECR) begin
						op = (instrReg[13:12] == INCR) ? ALU_INC : ALU_DEC;
						wrDest = 1'b1;
					end
				end
				default: ;
			endcase
		end
		highDst = isHighReg(dst);
		ctrl.aluOp = op;
		ctrl.destSel = dst;
		ctrl.destSel2 = wrSp ? SP_REG : dst;
	end

	// State gating of the decoded strobes
	always_comb begin
		wbPhase = ((state == ST_EXEC) && !isMem) || ((state == ST_WB) && isMem);
		ctrl.writeEn1 = wbPhase && wrDest && !highDst;
		ctrl.writeEn2 = wbPhase && ((wrDest && highDst) || wrSp);
		ctrl.flagWrite = (state == ST_EXEC) && flagWr;
		ctrl.pcLoad = (state == ST_EXEC);
		ctrl.memWrite = storeOp && (state != ST_FETCH);
		ctrl.addrSel = (state == ST_FETCH) ? ADR_PC : addrSelDec;
		ctrl.busReq = ((state == ST_FETCH) || (state == ST_MEM)) && !busDone;
	end

	////////////////////////////// Sequencer
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_FETCH;
		end else begin
			case (state)
				ST_FETCH: if (busDone) state <= ST_EXEC;
				ST_EXEC: state <= isMem ? ST_MEM : ST_FETCH;
				ST_MEM: if (busDone) state <= ST_WB;
				default: state <= ST_FETCH;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_FETCH && busDone)
			instrReg <= instruction;
	end

endmodule

/* aluUnit.sv */
module aluUnit (
	input  logic          clk,
	input  logic          rst,
	ctrlIf.dp             ctrl,
	input  isaPkg::dataT  operandA,
	input  isaPkg::dataT  operandB,
	output isaPkg::dataT  result,
	output isaPkg::flagsT flags
);
	import isaPkg::*;
	import corePkg::*;

	dataT opB, res;
	logic [16:0] diff;

	assign opB = (ctrl.operandSel == OPB_IMM) ? ctrl.immediate : operandB;
	// Extra bit holds the unsigned borrow
	assign diff = {1'b0, operandA} - {1'b0, opB};

	always_comb begin
		case (ctrl.aluOp)
			ADD: res = operandA + opB;
			SUB, CMP: res = diff[15:0];
			AND: res = operandA & opB;
			OR: res = operandA | opB;
			XOR: res = operandA ^ opB;
			NOT: res = ~opB;
			LSH: res = operandA << opB[3:0];
			RSH: res = operandA >> opB[3:0];
			ARSH: res = dataT'($signed(operandA) >>> opB[3:0]);
			MOVR: res = opB;
			ALU_INC: res = operandA + 16'd1;
			ALU_DEC: res = operandA - 16'd1;
			default: res = '0;
		endcase
	end

	assign result = res;

	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
		end else if (ctrl.flagWrite) begin
			flags.low <= (ctrl.aluOp == SUB || ctrl.aluOp == CMP) ? diff[16] : 1'b0;
			flags.negative <= res[15];
			flags.zero <= (res == '0);
		end
	end

endmodule

/* regFile.sv */
module regFile #(
	parameter int regCount = isaPkg::NUM_REGS
) (
	input  logic         clk,
	input  logic         rst,
	ctrlIf.dp            ctrl,
	input  isaPkg::dataT writeData,
	output isaPkg::dataT destData,
	output isaPkg::dataT srcData,
	output isaPkg::dataT spData
);
	import isaPkg::*;
	import corePkg::*;

	localparam int idxWidth = $clog2(regCount);
	localparam int spIdx = SP_REG % regCount;

	dataT regs [regCount];
	dataT spNext, port2Data;

	assign destData = regs[ctrl.destSel[idxWidth-1:0]];
	assign srcData = regs[ctrl.srcSel[idxWidth-1:0]];

	// Push uses SP then bumps it, pop works on SP-1
	assign spData = ctrl.memWrite ? regs[spIdx] : regs[spIdx] - 16'd1;
	assign spNext = ctrl.memWrite ? regs[spIdx] + 16'd1 : regs[spIdx] - 16'd1;
	assign port2Data = (ctrl.addrSel == ADR_SP) ? spNext : writeData;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end else begin
			if (ctrl.writeEn1)
				regs[ctrl.destSel[idxWidth-1:0]] <= writeData;
			if (ctrl.writeEn2)
				regs[ctrl.destSel2[idxWidth-1:0]] <= port2Data;
		end
	end

endmodule

/* pcUnit.sv */
module pcUnit (
	input  logic         clk,
	input  logic         rst,
	ctrlIf.dp            ctrl,
	input  isaPkg::dataT linkData,
	output isaPkg::dataT pc,
	output isaPkg::dataT pcPlusOne
);
	import corePkg::*;

	assign pcPlusOne = pc + 16'd1;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (ctrl.pcLoad) begin
			case (ctrl.pcSel)
				PC_JUMP: pc <= ctrl.address;
				PC_LINK: pc <= linkData;
				default: pc <= pcPlusOne;
			endcase
		end
	end

endmodule

/* wbMaster.sv */
module wbMaster (
	input  logic          clk,
	input  logic          rst,
	ctrlIf.dp             ctrl,
	input  isaPkg::dataT  pc,
	input  isaPkg::dataT  srcData,
	input  isaPkg::dataT  spData,
	input  isaPkg::dataT  storeData,
	input  isaPkg::instrT wbDatIn,
	input  logic          wbAck,
	output isaPkg::dataT  wbAdr,
	output isaPkg::dataT  wbDatOut,
	output logic          wbWe,
	output logic          wbCyc,
	output logic          wbStb,
	output isaPkg::instrT readData,
	output logic          busDone
);
	import isaPkg::*;
	import corePkg::*;

	dataT nextAdr;
	logic start;

	always_comb begin
		case (ctrl.addrSel)
			ADR_PC: nextAdr = pc;
			ADR_IMM: nextAdr = ctrl.address;
			ADR_SRCREG: nextAdr = srcData;
			default: nextAdr = spData;
		endcase
	end

	assign start = ctrl.busReq && !wbCyc;
	assign wbStb = wbCyc;

	////////////////////////////// Classic cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			wbCyc <= 1'b0;
			wbWe <= 1'b0;
			busDone <= 1'b0;
		end else begin
			busDone <= 1'b0;
			if (wbCyc && wbAck) begin
				wbCyc <= 1'b0;
				wbWe <= 1'b0;
				busDone <= 1'b1;
			end else if (start) begin
				wbCyc <= 1'b1;
				wbWe <= ctrl.memWrite;
			end
		end
	end

	// Address and data held for the whole cycle
	always_ff @(posedge clk) begin
		if (start) begin
			wbAdr <= nextAdr;
			wbDatOut <= storeData;
		end
		if (wbCyc && wbAck)
			readData <= wbDatIn;
	end

endmodule

/* cpuTop.sv */
module cpuTop (
	input  logic          clk,
	input  logic          rst,
	input  isaPkg::instrT wbDatIn,
	input  logic          wbAck,
	output isaPkg::dataT  wbAdr,
	output isaPkg::dataT  wbDatOut,
	output logic          wbWe,
	output logic          wbCyc,
	output logic          wbStb
);
	import isaPkg::*;
	import corePkg::*;

	dataT aluResult, writeData;
	dataT destData, srcData, spData;
	dataT pc, pcPlusOne;
	instrT readData;
	flagsT flags;
	logic busDone;

	ctrlIf ctrlBus ();

	// Write-back source
	assign writeData = (ctrlBus.wbDataSel == WB_MEM) ? readData[15:0] :
		(ctrlBus.wbDataSel == WB_PCLINK) ? pcPlusOne : aluResult;

	controlUnit i_controlUnit (
		.clk         (clk),
		.rst         (rst),
		.instruction (readData),
		.flags       (flags),
		.busDone     (busDone),
		.ctrl        (ctrlBus.ctrl)
	);

	aluUnit i_aluUnit (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrlBus.dp),
		.operandA (destData),
		.operandB (srcData),
		.result   (aluResult),
		.flags    (flags)
	);

	regFile i_regFile (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrlBus.dp),
		.writeData (writeData),
		.destData  (destData),
		.srcData   (srcData),
		.spData    (spData)
	);

	pcUnit i_pcUnit (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrlBus.dp),
		.linkData  (srcData),
		.pc        (pc),
		.pcPlusOne (pcPlusOne)
	);

	wbMaster i_wbMaster (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrlBus.dp),
		.pc        (pc),
		.srcData   (srcData),
		.spData    (spData),
		.storeData (destData),
		.wbDatIn   (wbDatIn),
		.wbAck     (wbAck),
		.wbAdr     (wbAdr),
		.wbDatOut  (wbDatOut),
		.wbWe      (wbWe),
		.wbCyc     (wbCyc),
		.wbStb     (wbStb),
		.readData  (readData),
		.busDone   (busDone)
	);

endmodule

/* tbChecker.sv */
module tbChecker (
	input  logic             clk,
	input  logic             rst,
	input  logic             wbCyc,
	input  logic             wbStb,
	input  logic             wbWe,
	input  logic             wbAck,
	input  logic [15:0]      wbAdr,
	input  logic [15:0]      wbDatOut,
	input  logic [3:0][15:0] expAdr,
	input  logic [3:0][15:0] expDat,
	input  int               expCount,
	output int               storeCount,
	output int               errorCount
);
	timeunit 1ns;
	timeprecision 100ps;

	int stores = 0;
	int errors = 0;

	assign storeCount = stores;
	assign errorCount = errors;

	// A write completes on the edge that sees ack
	always @(posedge clk) begin : compareStore
		int bad;
		bad = 0;
		if (rst) begin
			stores <= 0;
		end else begin
			// Classic bus raises strobe together with cycle
			if (wbStb !== wbCyc) begin
				$display("mismatch at %0t: wbStb expected %b actual %b",
					$time, wbCyc, wbStb);
				bad++;
			end
			if (wbCyc && wbStb && wbWe && wbAck) begin
				if (stores >= expCount) begin
					$display("unexpected store at %0t to address %h, only %0d stores expected",
						$time, wbAdr, expCount);
					bad++;
				end else begin
					if (wbAdr !== expAdr[stores]) begin
						$display("mismatch at %0t: wbAdr expected %h actual %h",
							$time, expAdr[stores], wbAdr);
						bad++;
					end
					if (wbDatOut !== expDat[stores]) begin
						$display("mismatch at %0t: wbDatOut expected %h actual %h",
							$time, expDat[stores], wbDatOut);
						bad++;
					end
				end
				stores <= stores + 1;
			end
			errors <= errors + bad;
		end
	end

endmodule

/* tbCpu.sv */
module tbCpu;
	timeunit 1ns;
	timeprecision 100ps;
	import isaPkg::*;

	localparam int NUM_CASES = 8;
	localparam int PROG_WORDS = 16;
	localparam int MAX_STORES = 4;
	localparam int TIMEOUT_CYCLES = 2000;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic wbAck = 1'b0;
	instrT wbDatIn = '0;
	dataT wbAdr, wbDatOut;
	logic wbWe, wbCyc, wbStb;

	////////////////////////////// Case table
	instrT progTable [NUM_CASES][PROG_WORDS];
	dataT adrTable [NUM_CASES][MAX_STORES];
	dataT datTable [NUM_CASES][MAX_STORES];
	int countTable [NUM_CASES];
	int caseIdx, wordIdx;

	logic [3:0][15:0] expAdr = '0;
	logic [3:0][15:0] expDat = '0;
	int expCount = 0;
	int storeCount, errorCount;
	int timeouts = 0;

	instrT mem [256];
	integer seed = 34;
	int waitLeft = -1;

	initial begin
		forever #4 clk = ~clk;
	end

	cpuTop i_cpuTop (
		.clk      (clk),
		.rst      (rst),
		.wbDatIn  (wbDatIn),
		.wbAck    (wbAck),
		.wbAdr    (wbAdr),
		.wbDatOut (wbDatOut),
		.wbWe     (wbWe),
		.wbCyc    (wbCyc),
		.wbStb    (wbStb)
	);

	tbChecker storeCheck (
		.clk        (clk),
		.rst        (rst),
		.wbCyc      (wbCyc),
		.wbStb      (wbStb),
		.wbWe       (wbWe),
		.wbAck      (wbAck),
		.wbAdr      (wbAdr),
		.wbDatOut   (wbDatOut),
		.expAdr     (expAdr),
		.expDat     (expDat),
		.expCount   (expCount),
		.storeCount (storeCount),
		.errorCount (errorCount)
	);

	// Memory decodes only the low address byte and adds 0 to 3 wait states
	always @(negedge clk) begin : memoryModel
		int delay;
		delay = 0;
		if (rst || wbAck || !(wbCyc && wbStb)) begin
			wbAck <= 1'b0;
			waitLeft <= -1;
		end else begin
			delay = (waitLeft < 0) ? int'($unsigned($random(seed)) % 4) : waitLeft;
			if (delay == 0) begin
				wbAck <= 1'b1;
				wbDatIn <= mem[wbAdr[7:0]];
				if (wbWe)
					mem[wbAdr[7:0]] = {2'b00, wbDatOut};
				waitLeft <= -1;
			end else begin
				waitLeft <= delay - 1;
			end
		end
	end

	////////////////////////////// Instruction encoders
	function automatic instrT immOp(opcodeT op, regSelT rd, logic [7:0] imm);
		return {2'b00, op, rd, imm};
	endfunction

	function automatic instrT regOp(opcodeT op, regSelT rd, regSelT rs);
		return {2'b00, 4'd0, rd, op, rs};
	endfunction

	function automatic instrT indirectMem(opcodeT sub, regSelT rd, regSelT rs);
		return {2'b00, 4'd1, rd, sub, rs};
	endfunction

	// Register field sits inside the 14-bit address
	function automatic instrT absMem(opcodeT opc, regSelT r, logic [7:0] lo);
		return {opc, 2'b00, r, lo};
	endfunction

	function automatic instrT branchTo(opcodeT opc, int target);
		return {opc, 14'(target)};
	endfunction

	function automatic instrT stackOp(opcodeT opc, regSelT r);
		return {opc, r, 10'd0};
	endfunction

	function automatic instrT stepReg(logic [1:0] dir, regSelT r);
		return {INCDEC, dir, r, 8'd0};
	endfunction

	////////////////////////////// Table building
	task automatic startCase(int idx);
		caseIdx = idx;
		wordIdx = 0;
		countTable[idx] = 0;
		for (int i = 0; i < PROG_WORDS; i++)
			progTable[idx][i] = '0;
	endtask

	task automatic emit(instrT word);
		progTable[caseIdx][wordIdx] = word;
		wordIdx++;
	endtask

	task automatic expectStore(dataT adr, dataT dat);
		adrTable[caseIdx][countTable[caseIdx]] = adr;
		datTable[caseIdx][countTable[caseIdx]] = dat;
		countTable[caseIdx]++;
	endtask

	// r7 ends up 1 when the branch is taken and 2 when it falls through
	task automatic branchCheck(opcodeT cond, logic [7:0] lo, logic taken);
		int here;
		here = wordIdx;
		emit(immOp(MOVR, 4'd7, 8'd1));
		emit(branchTo(cond, here + 3));
		emit(immOp(MOVR, 4'd7, 8'd2));
		emit(absMem(MOVRMI, 4'd7, lo));
		expectStore({8'h07, lo}, taken ? 16'd1 : 16'd2);
	endtask

	task automatic haltLoop(opcodeT cond);
		emit(branchTo(cond, wordIdx));
	endtask

	task automatic buildCases();
		// ALU operations with results in r1 and r4
		startCase(0);
		emit(immOp(MOVR, 4'd1, 8'h5A));
		emit(immOp(ADD, 4'd1, 8'h30));
		emit(immOp(MOVR, 4'd2, 8'h0F));
		emit(regOp(SUB, 4'd1, 4'd2));
		emit(immOp(AND, 4'd1, 8'h3C));
		emit(regOp(OR, 4'd1, 4'd2));
		emit(immOp(XOR, 4'd1, 8'hFF));
		emit(immOp(LSH, 4'd1, 8'd4));
		emit(regOp(NOT, 4'd3, 4'd1));
		emit(immOp(ARSH, 4'd3, 8'd4));
		emit(immOp(RSH, 4'd1, 8'd2));
		emit(regOp(MOVR, 4'd4, 4'd3));
		emit(absMem(MOVRMI, 4'd1, 8'h80));
		emit(absMem(MOVRMI, 4'd4, 8'h81));
		haltLoop(JNE);
		expectStore(16'h0180, 16'h0300);
		expectStore(16'h0481, 16'hFF3F);
		// Comparing 5 with 7 sets low and negative
		startCase(1);
		emit(immOp(MOVR, 4'd1, 8'd5));
		emit(immOp(MOVR, 4'd2, 8'd7));
		emit(regOp(CMP, 4'd1, 4'd2));
		branchCheck(JL, 8'h90, 1'b1);
		branchCheck(JNE, 8'h91, 1'b1);
		branchCheck(JE, 8'h92, 1'b0);
		haltLoop(JNE);
		// Equal operands set zero only
		startCase(2);
		emit(immOp(MOVR, 4'd1, 8'd7));
		emit(immOp(CMP, 4'd1, 8'd7));
		branchCheck(JLE, 8'h90, 1'b1);
		branchCheck(JL, 8'h91, 1'b0);
		branchCheck(JNE, 8'h92, 1'b0);
		haltLoop(JE);
		// FFFF minus 1 is negative without a borrow
		startCase(3);
		emit(regOp(NOT, 4'd1, 4'd0));
		emit(immOp(CMP, 4'd1, 8'd1));
		branchCheck(JL, 8'h90, 1'b1);
		branchCheck(JLE, 8'h91, 1'b1);
		branchCheck(JE, 8'h92, 1'b0);
		haltLoop(JNE);
		// 9 minus 4 leaves every flag clear
		startCase(4);
		emit(immOp(MOVR, 4'd1, 8'd9));
		emit(immOp(CMP, 4'd1, 8'd4));
		branchCheck(JLE, 8'h90, 1'b0);
		branchCheck(JL, 8'h91, 1'b0);
		branchCheck(JNE, 8'h92, 1'b1);
		haltLoop(JNE);
		// Loads and stores where 05A0 aliases 03A0 in the memory model
		startCase(5);
		emit(immOp(MOVR, 4'd1, 8'hA5));
		emit(immOp(MOVR, 4'd2, 8'h90));
		emit(indirectMem(MOVRM, 4'd1, 4'd2));
		emit(indirectMem(MOVMR, 4'd3, 4'd2));
		emit(immOp(MOVR, 4'd4, 8'h91));
		emit(indirectMem(MOVRM, 4'd3, 4'd4));
		emit(immOp(ADD, 4'd3, 8'h11));
		emit(absMem(MOVRMI, 4'd3, 8'hA0));
		emit(absMem(MOVMRI, 4'd5, 8'hA0));
		emit(absMem(MOVRMI, 4'd5, 8'hA1));
		haltLoop(JNE);
		expectStore(16'h0090, 16'h00A5);
		expectStore(16'h0091, 16'h00A5);
		expectStore(16'h03A0, 16'h00B6);
		expectStore(16'h05A1, 16'h00B6);
		// Stack ops where the POP into SP leaves it alone
		startCase(6);
		emit(immOp(MOVR, SP_REG, 8'hC0));
		emit(immOp(MOVR, 4'd1, 8'h3C));
		emit(stackOp(PUSH, 4'd1));
		emit(stackOp(POP, 4'd2));
		emit(absMem(MOVRMI, 4'd2, 8'hD0));
		emit(stackOp(POP, SP_REG));
		emit(absMem(MOVRMI, SP_REG, 8'hD1));
		haltLoop(JNE);
		expectStore(16'h00C0, 16'h003C);
		expectStore(16'h02D0, 16'h003C);
		expectStore(16'h0DD1, 16'h00C0);
		// Subroutine at 5 steps the link register up and back down
		startCase(7);
		emit(immOp(MOVR, 4'd1, 8'h11));
		emit(branchTo(CALL, 5));
		emit(absMem(MOVRMI, LINK_REG, 8'hE3));
		haltLoop(JNE);
		emit('0);
		emit(absMem(MOVRMI, 4'd1, 8'hE0));
		emit(stepReg(INCR, LINK_REG));
		emit(absMem(MOVRMI, LINK_REG, 8'hE2));
		emit(stepReg(DECR, LINK_REG));
		emit(branchTo(RET, 0));
		expectStore(16'h01E0, 16'h0011);
		expectStore(16'h0CE2, 16'h0003);
		expectStore(16'h0CE3, 16'h0002);
	endtask

	task automatic loadProgram(int c);
		for (int a = 0; a < 256; a++)
			mem[a] = {2'b10, 8'(a), ~8'(a)};
		for (int a = 0; a < PROG_WORDS; a++)
			mem[a] = progTable[c][a];
		for (int k = 0; k < MAX_STORES; k++) begin
			expAdr[k] = (k < countTable[c]) ? adrTable[c][k] : 16'h0;
			expDat[k] = (k < countTable[c]) ? datTable[c][k] : 16'h0;
		end
		expCount = countTable[c];
	endtask

	////////////////////////////// Run loop
	initial begin : runCases
		int cycles;
		cycles = 0;
		buildCases();
		for (int c = 0; c < NUM_CASES; c++) begin
			rst <= 1'b1;
			@(negedge clk);
			loadProgram(c);
			repeat (4) @(negedge clk);
			rst <= 1'b0;
			cycles = 0;
			while (storeCount < expCount && cycles < TIMEOUT_CYCLES) begin
				@(negedge clk);
				cycles++;
			end
			if (storeCount < expCount) begin
				$display("timeout in case %0d: only %0d of %0d stores seen in %0d cycles",
					c, storeCount, expCount, TIMEOUT_CYCLES);
				timeouts++;
			end
		end
		@(negedge clk);
		$display("errors=%0d timeouts=%0d", errorCount, timeouts);
		if (errorCount == 0 && timeouts == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* vlog.f */
isaPkg.sv
corePkg.sv
ctrlIf.sv
controlUnit.sv
aluUnit.sv
regFile.sv
pcUnit.sv
wbMaster.sv
cpuTop.sv
tbChecker.sv
tbCpu.sv

/* run.sh */
#!/bin/bash
# Build with Verilator, run, then decide on the log contents
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tbCpu -f vlog.f -o simCpu \
	&& ./obj_dir/simCpu | tee sim.log \
	|| { echo "build or simulation error"; exit 1; }
grep -q "^TB PASSED$" sim.log && echo "run ok" || { echo "run failed"; exit 1; }
